// ==== Bender.yml ====
package:
  name: gemm_accel

export_include_dirs:
  - .

sources:
  - gemm_pkg.sv
  - axi_ch_if.sv
  - operand_buffer.sv
  - mm_engine.sv
  - dma_engine.sv
  - gemm_top.sv
  - target: simulation
    files:
      - tb_gemm.sv

// ==== axi_ch_if.sv ====
// AXI-style read (AR/R) and write (AW/W/B) channel bundles.
// The DMA engine is master on both; the top level ties the slave side to ports.
`timescale 1ns/1ps
`default_nettype none

interface axi_rd_if;
    import gemm_pkg::*;

    logic       arvalid;
    logic       arready;
    axi_addr_t  araddr;
    logic [7:0] arlen;
    axi_id_t    arid;

    logic       rvalid;
    logic       rready;
    axi_data_t  rdata;
    axi_id_t    rid;
    logic       rlast;

    modport master (
        output arvalid, araddr, arlen, arid, rready,
        input  arready, rvalid, rdata, rid, rlast
    );

    modport slave (
        input  arvalid, araddr, arlen, arid, rready,
        output arready, rvalid, rdata, rid, rlast
    );
endinterface

interface axi_wr_if;
    import gemm_pkg::*;

    logic       awvalid;
    logic       awready;
    axi_addr_t  awaddr;
    logic [7:0] awlen;

    logic       wvalid;
    logic       wready;
    axi_data_t  wdata;
    logic       wlast;

    // no response code, every B counts as success
    logic       bvalid;
    logic       bready;

    modport master (
        output awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
        input  awready, wready, bvalid
    );

    modport slave (
        input  awvalid, awaddr, awlen, wvalid, wdata, wlast, bready,
        output awready, wready, bvalid
    );
endinterface

`default_nettype wire

// ==== dma_engine.sv ====
// DMA controller: reads A and B into the operand buffers, runs the multiply
// engine, then writes the 4x4 result back as 16 sign-extended beats.
// Pulse start_i while idle; done_o pulses once the write response is in.
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module dma_engine (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire gemm_pkg::axi_addr_t   mat_a_addr_i,
    input  wire gemm_pkg::axi_addr_t   mat_b_addr_i,
    input  wire gemm_pkg::axi_addr_t   mat_c_addr_i,
    input  wire [4:0]                  mat_width_i,
    input  wire                        start_i,
    output logic                       done_o,
    axi_rd_if.master                   rd_if,
    axi_wr_if.master                   wr_if,
    output logic                       buf_a_wr_en_o,
    output gemm_pkg::buf_addr_t        buf_a_wr_addr_o,
    output gemm_pkg::buf_word_u        buf_a_wr_data_o,
    output logic                       buf_b_wr_en_o,
    output gemm_pkg::buf_addr_t        buf_b_wr_addr_o,
    output gemm_pkg::buf_word_u        buf_b_wr_data_o,
    output logic                       mm_start_o,
    input  wire                        mm_done_i,
    input  wire gemm_pkg::acc_matrix_t acc_i
);
    import gemm_pkg::*;

    localparam int N_ELEM = `GEMM_SA_WIDTH * `GEMM_SA_WIDTH;
    localparam int CNT_W  = $clog2(N_ELEM);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR_A,
        S_ADDR_B,
        S_LOAD,
        S_WAIT_MM,
        S_ADDR_C,
        S_WRITE_C,
        S_WAIT_RESP
    } state_t;

    state_t           state_q;
    state_t           state_d;
    logic [4:0]       cnt_a_q;
    logic [4:0]       cnt_b_q;
    logic [CNT_W-1:0] cnt_c_q;
    logic             r_hs;
    logic             r_is_a;
    logic             load_done;
    acc_t             acc_sel;

    assign r_hs      = rd_if.rvalid && rd_if.rready;
    assign r_is_a    = (rd_if.rid == axi_id_t'(0));
    assign load_done = (cnt_a_q == mat_width_i) && (cnt_b_q == mat_width_i);

    // read requests, payload held by the state until arready
    assign rd_if.arvalid = (state_q == S_ADDR_A) || (state_q == S_ADDR_B);
    assign rd_if.araddr  = (state_q == S_ADDR_B) ? mat_b_addr_i : mat_a_addr_i;
    assign rd_if.arid    = (state_q == S_ADDR_B) ? axi_id_t'(1) : axi_id_t'(0);
    assign rd_if.arlen   = 8'(mat_width_i) - 8'd1;
    assign rd_if.rready  = (state_q == S_LOAD);

    // beats sorted by rid, each buffer with its own running address
    assign buf_a_wr_en_o       = r_hs && r_is_a;
    assign buf_a_wr_addr_o     = cnt_a_q[`GEMM_BUF_AW-1:0];
    assign buf_a_wr_data_o.raw = rd_if.rdata;
    assign buf_b_wr_en_o       = r_hs && !r_is_a;
    assign buf_b_wr_addr_o     = cnt_b_q[`GEMM_BUF_AW-1:0];
    assign buf_b_wr_data_o.raw = rd_if.rdata;

    // result write, row-major
    assign acc_sel        = acc_i[cnt_c_q];
    assign wr_if.awvalid  = (state_q == S_ADDR_C);
    assign wr_if.awaddr   = mat_c_addr_i;
    assign wr_if.awlen    = 8'(N_ELEM - 1);
    assign wr_if.wvalid   = (state_q == S_WRITE_C);
    assign wr_if.wdata    = {{(`GEMM_AXI_DW - `GEMM_ACC_W){acc_sel[`GEMM_ACC_W-1]}}, acc_sel};
    assign wr_if.wlast    = wr_if.wvalid && (cnt_c_q == CNT_W'(N_ELEM - 1));
    assign wr_if.bready   = (state_q == S_WAIT_RESP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
                if (start_i) state_d = S_ADDR_A;
            S_ADDR_A:
                if (rd_if.arready) state_d = S_ADDR_B;
            S_ADDR_B:
                if (rd_if.arready) state_d = S_LOAD;
            S_LOAD:
                if (load_done) state_d = S_WAIT_MM;
            S_WAIT_MM:
                if (mm_done_i) state_d = S_ADDR_C;
            S_ADDR_C:
                if (wr_if.awready) state_d = S_WRITE_C;
            S_WRITE_C:
                if (wr_if.wready && wr_if.wlast) state_d = S_WAIT_RESP;
            S_WAIT_RESP:
                if (wr_if.bvalid) state_d = S_IDLE;
            default:
                state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            cnt_a_q    <= '0;
            cnt_b_q    <= '0;
            cnt_c_q    <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            state_q    <= state_d;
            // one-cycle strobes on leaving load and on the B handshake
            mm_start_o <= (state_q == S_LOAD) && load_done;
            done_o     <= (state_q == S_WAIT_RESP) && wr_if.bvalid;
            if (state_q == S_IDLE) begin
                cnt_a_q <= '0;
                cnt_b_q <= '0;
                cnt_c_q <= '0;
            end
            if (buf_a_wr_en_o) begin
                cnt_a_q <= cnt_a_q + 5'd1;
            end
            if (buf_b_wr_en_o) begin
                cnt_b_q <= cnt_b_q + 5'd1;
            end
            if (wr_if.wvalid && wr_if.wready) begin
                cnt_c_q <= cnt_c_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== gemm_params.svh ====
// Shared size constants for the 4x4 int8 matrix-multiply accelerator.
// Included by the package and by any RTL that sizes logic from them.
`ifndef GEMM_PARAMS_SVH
`define GEMM_PARAMS_SVH

// array side, the result is SA x SA
`define GEMM_SA_WIDTH 4
`define GEMM_ELEM_W   8

// two element widths plus 4 guard bits for up to 16 products
`define GEMM_ACC_W    20

// buffer depth is 2**BUF_AW words, so W up to 16
`define GEMM_BUF_AW   4

`define GEMM_AXI_AW   32
`define GEMM_AXI_DW   32
`define GEMM_AXI_IDW  1

`endif

// ==== gemm_pkg.sv ====
// Types shared by the accelerator RTL and its testbench.
// Import where the types are used; widths come from the params header.
`default_nettype none

`include "gemm_params.svh"

package gemm_pkg;

    typedef logic [`GEMM_AXI_AW-1:0]  axi_addr_t;
    typedef logic [`GEMM_AXI_DW-1:0]  axi_data_t;
    // 0 for matrix A, 1 for matrix B
    typedef logic [`GEMM_AXI_IDW-1:0] axi_id_t;
    typedef logic [`GEMM_BUF_AW-1:0]  buf_addr_t;

    typedef logic signed [`GEMM_ELEM_W-1:0] elem_t;
    typedef logic signed [`GEMM_ACC_W-1:0]  acc_t;

    // entry i*SA+j holds C[i][j]
    typedef acc_t [`GEMM_SA_WIDTH*`GEMM_SA_WIDTH-1:0] acc_matrix_t;

    // DMA fills a whole beat, the multiply side picks lanes, lane 0 in the low byte
    typedef union packed {
        axi_data_t                      raw;
        elem_t [`GEMM_SA_WIDTH-1:0]     lane;
    } buf_word_u;

endpackage

`default_nettype wire

// ==== gemm_top.sv ====
// Top level of the matrix-multiply accelerator.
// Maps plain AXI-style ports onto the channel bundles and wires the blocks.
`timescale 1ns/1ps
`default_nettype none

module gemm_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start_i,
    output logic                     done_o,
    input  wire gemm_pkg::axi_addr_t mat_a_addr_i,
    input  wire gemm_pkg::axi_addr_t mat_b_addr_i,
    input  wire gemm_pkg::axi_addr_t mat_c_addr_i,
    input  wire [4:0]                mat_width_i,
    output logic                     arvalid_o,
    input  wire                      arready_i,
    output gemm_pkg::axi_addr_t      araddr_o,
    output logic [7:0]               arlen_o,
    output gemm_pkg::axi_id_t        arid_o,
    input  wire                      rvalid_i,
    output logic                     rready_o,
    input  wire gemm_pkg::axi_data_t rdata_i,
    input  wire gemm_pkg::axi_id_t   rid_i,
    input  wire                      rlast_i,
    output logic                     awvalid_o,
    input  wire                      awready_i,
    output gemm_pkg::axi_addr_t      awaddr_o,
    output logic [7:0]               awlen_o,
    output logic                     wvalid_o,
    input  wire                      wready_i,
    output gemm_pkg::axi_data_t      wdata_o,
    output logic                     wlast_o,
    input  wire                      bvalid_i,
    output logic                     bready_o
);
    import gemm_pkg::*;

    axi_rd_if rd_bus ();
    axi_wr_if wr_bus ();

    logic        buf_a_wr_en;
    logic        buf_b_wr_en;
    buf_addr_t   buf_a_wr_addr;
    buf_addr_t   buf_b_wr_addr;
    buf_word_u   buf_a_wr_data;
    buf_word_u   buf_b_wr_data;
    buf_addr_t   buf_rd_addr;
    buf_word_u   buf_a_rd_data;
    buf_word_u   buf_b_rd_data;
    logic        mm_start;
    logic        mm_done;
    acc_matrix_t acc;

    // slave side of the read channel
    assign arvalid_o     = rd_bus.arvalid;
    assign rd_bus.arready = arready_i;
    assign araddr_o      = rd_bus.araddr;
    assign arlen_o       = rd_bus.arlen;
    assign arid_o        = rd_bus.arid;
    assign rd_bus.rvalid = rvalid_i;
    assign rready_o      = rd_bus.rready;
    assign rd_bus.rdata  = rdata_i;
    assign rd_bus.rid    = rid_i;
    assign rd_bus.rlast  = rlast_i;

    // slave side of the write channel
    assign awvalid_o      = wr_bus.awvalid;
    assign wr_bus.awready = awready_i;
    assign awaddr_o       = wr_bus.awaddr;
    assign awlen_o        = wr_bus.awlen;
    assign wvalid_o       = wr_bus.wvalid;
    assign wr_bus.wready  = wready_i;
    assign wdata_o        = wr_bus.wdata;
    assign wlast_o        = wr_bus.wlast;
    assign wr_bus.bvalid  = bvalid_i;
    assign bready_o       = wr_bus.bready;

    dma_engine dma_engine_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .mat_a_addr_i    (mat_a_addr_i),
        .mat_b_addr_i    (mat_b_addr_i),
        .mat_c_addr_i    (mat_c_addr_i),
        .mat_width_i     (mat_width_i),
        .start_i         (start_i),
        .done_o          (done_o),
        .rd_if           (rd_bus.master),
        .wr_if           (wr_bus.master),
        .buf_a_wr_en_o   (buf_a_wr_en),
        .buf_a_wr_addr_o (buf_a_wr_addr),
        .buf_a_wr_data_o (buf_a_wr_data),
        .buf_b_wr_en_o   (buf_b_wr_en),
        .buf_b_wr_addr_o (buf_b_wr_addr),
        .buf_b_wr_data_o (buf_b_wr_data),
        .mm_start_o      (mm_start),
        .mm_done_i       (mm_done),
        .acc_i           (acc)
    );

    operand_buffer buf_a_inst (
        .clk       (clk),
        .wr_en_i   (buf_a_wr_en),
        .wr_addr_i (buf_a_wr_addr),
        .wr_data_i (buf_a_wr_data),
        .rd_addr_i (buf_rd_addr),
        .rd_data_o (buf_a_rd_data)
    );

    operand_buffer buf_b_inst (
        .clk       (clk),
        .wr_en_i   (buf_b_wr_en),
        .wr_addr_i (buf_b_wr_addr),
        .wr_data_i (buf_b_wr_data),
        .rd_addr_i (buf_rd_addr),
        .rd_data_o (buf_b_rd_data)
    );

    mm_engine mm_engine_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (mm_start),
        .mat_width_i (mat_width_i),
        .rd_addr_o   (buf_rd_addr),
        .a_word_i    (buf_a_rd_data),
        .b_word_i    (buf_b_rd_data),
        .done_o      (mm_done),
        .acc_o       (acc)
    );

endmodule

`default_nettype wire

// ==== gemm_vectors.hex ====
// per case: W, A address, B address, C address; then W A column words,
// W B row words and 16 expected C words, row-major; W = 0 ends the list
00000001 00001000 00002000 00003000
7F03FE01
0580FF02
00000002 FFFFFFFF FFFFFF80 00000005
FFFFFFFC 00000002 00000100 FFFFFFF6
00000006 FFFFFFFD FFFFFE80 0000000F
000000FE FFFFFF81 FFFFC080 0000027B
00000004 00010000 00010100 00020000
01000001 0000FF02 00030000 FE000000
D81EEC0A 04030201 08F906FB CE329C64
0000000C FFFFFFF0 00000024 FFFFFFE0
FFFFFFFF FFFFFFFE FFFFFFFD FFFFFFFC
FFFFFFF1 00000012 FFFFFFEB 00000018
FFFFFF42 000000B4 FFFFFFBA 0000003C
00000010 00040000 00050000 00060000
8000FF03 8001FF03 8002FF03 8003FF03 8004FF03 8005FF03 8006FF03 8007FF03
8008FF03 8009FF03 800AFF03 800BFF03 800CFF03 800DFF03 800EFF03 800FFF03
7F800000 7F80FF01 7F80FE02 7F80FD03 7F80FC04 7F80FB05 7F80FA06 7F80F907
7F80F808 7F80F709 7F80F60A 7F80F50B 7F80F40C 7F80F30D 7F80F20E 7F80F10F
00000168 FFFFFE98 FFFFE800 000017D0
FFFFFF88 00000078 00000800 FFFFF810
000004D8 FFFFFB28 FFFFC400 00003B88
FFFFC400 00003C00 00040000 FFFC0800
00000000 00000000 00000000 00000000

// ==== mm_engine.sv ====
// Outer-product multiply engine for a 4xW by Wx4 int8 product.
// Pulse start_i; done_o pulses W+2 cycles later with the 4x4 sums on acc_o.
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module mm_engine (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start_i,
    input  wire [4:0]                mat_width_i,
    output gemm_pkg::buf_addr_t      rd_addr_o,
    input  wire gemm_pkg::buf_word_u a_word_i,
    input  wire gemm_pkg::buf_word_u b_word_i,
    output logic                     done_o,
    output gemm_pkg::acc_matrix_t    acc_o
);
    import gemm_pkg::*;

    localparam int N      = `GEMM_SA_WIDTH;
    localparam int PROD_W = 2 * `GEMM_ELEM_W;

    buf_addr_t   idx_q;
    logic        run_q;
    // buffer outputs hold a valid word this cycle
    logic        vld_q;
    logic        last_q;
    logic        last_idx;
    acc_matrix_t acc_q;
    logic signed [PROD_W-1:0] prod [N*N];

    assign last_idx  = ({1'b0, idx_q} == mat_width_i - 5'd1);
    assign rd_addr_o = idx_q;
    assign acc_o     = acc_q;

    // word index walk plus the delayed valid for the read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            idx_q  <= '0;
            vld_q  <= 1'b0;
            last_q <= 1'b0;
            done_o <= 1'b0;
        end else begin
            vld_q  <= run_q;
            last_q <= run_q && last_idx;
            done_o <= last_q;
            if (start_i) begin
                run_q <= 1'b1;
                idx_q <= '0;
            end else if (run_q) begin
                idx_q <= idx_q + 1'b1;
                if (last_idx) begin
                    run_q <= 1'b0;
                end
            end
        end
    end

    // A column lane i times B row lane j
    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                prod[i*N+j] = a_word_i.lane[i] * b_word_i.lane[j];
            end
        end
    end

    // sums stay put after done until the next start
    always_ff @(posedge clk) begin
        for (int n = 0; n < N * N; n++) begin
            if (start_i) begin
                acc_q[n] <= '0;
            end else if (vld_q) begin
                acc_q[n] <= acc_q[n] + prod[n];
            end
        end
    end

endmodule

`default_nettype wire

// ==== operand_buffer.sv ====
// Simple dual-port operand buffer, one word per A column or B row.
// Write port from the DMA, registered read port to the multiply engine.
`timescale 1ns/1ps
`default_nettype none

`include "gemm_params.svh"

module operand_buffer (
    input  wire                      clk,
    input  wire                      wr_en_i,
    input  wire gemm_pkg::buf_addr_t wr_addr_i,
    input  wire gemm_pkg::buf_word_u wr_data_i,
    input  wire gemm_pkg::buf_addr_t rd_addr_i,
    output gemm_pkg::buf_word_u      rd_data_o
);
    import gemm_pkg::*;

    localparam int DEPTH = 1 << `GEMM_BUF_AW;

    buf_word_u mem [DEPTH];

    // data shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== tb_gemm.sv ====
// Testbench for the matrix-multiply accelerator top level.
// Reads cases from the vector file, serves AXI reads and writes with random
// back-pressure, and checks every request, result beat and done pulse.
`timescale 1ns/1ps
`default_nettype none

module tb_gemm;
    import gemm_pkg::*;

    localparam int    SEED         = 90;
    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 10;
    localparam int    CASE_CYCLES  = 400;
    localparam int    VEC_DEPTH    = 512;
    localparam string VEC_FILE     = "gemm_vectors.hex";

    logic       clk;
    logic       rst_n;
    logic       start_i;
    logic       done_o;
    axi_addr_t  mat_a_addr_i;
    axi_addr_t  mat_b_addr_i;
    axi_addr_t  mat_c_addr_i;
    logic [4:0] mat_width_i;
    logic       arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;
    axi_addr_t  araddr_o;
    logic [7:0] arlen_o;
    axi_id_t    arid_o;
    axi_id_t    rid_i;
    axi_data_t  rdata_i;
    logic       awvalid_o, awready_i, wvalid_o, wready_i, wlast_o, bvalid_i, bready_o;
    axi_addr_t  awaddr_o;
    logic [7:0] awlen_o;
    axi_data_t  wdata_o;

    // whole vector file image, then the current case split out
    logic [31:0] vec_mem [VEC_DEPTH];
    axi_data_t   a_words [16];
    axi_data_t   b_words [16];
    axi_data_t   c_exp   [16];
    int          width;
    int          n_cases;
    int          done_count;
    logic        b_hs_last;

    gemm_top gemm_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .done_o       (done_o),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .mat_width_i  (mat_width_i),
        .arvalid_o (arvalid_o), .arready_i (arready_i), .araddr_o (araddr_o),
        .arlen_o   (arlen_o),   .arid_o    (arid_o),
        .rvalid_i  (rvalid_i),  .rready_o  (rready_o),  .rdata_i  (rdata_i),
        .rid_i     (rid_i),     .rlast_i   (rlast_i),
        .awvalid_o (awvalid_o), .awready_i (awready_i), .awaddr_o (awaddr_o),
        .awlen_o   (awlen_o),
        .wvalid_o  (wvalid_o),  .wready_i  (wready_i),  .wdata_o  (wdata_o),
        .wlast_o   (wlast_o),
        .bvalid_i  (bvalid_i),  .bready_o  (bready_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // drive point 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic random_wait();
        int n;
        n = $urandom_range(3);
        repeat (n) tick();
    endtask

    task automatic check_quiet();
        check_flag("arvalid_o", arvalid_o, 1'b0);
        check_flag("rready_o", rready_o, 1'b0);
        check_flag("awvalid_o", awvalid_o, 1'b0);
        check_flag("wvalid_o", wvalid_o, 1'b0);
        check_flag("bready_o", bready_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
    endtask

    // two AR requests in order then randomly interleaved A and B beats
    task automatic serve_reads(input axi_addr_t a_addr, input axi_addr_t b_addr);
        int   ia;
        int   ib;
        logic pick_b;
        for (int n = 0; n < 2; n++) begin
            while (!arvalid_o) tick();
            random_wait();
            check_addr("araddr_o", araddr_o, (n == 0) ? a_addr : b_addr);
            check_id("arid_o", arid_o, axi_id_t'(n));
            check_len("arlen_o", arlen_o, 8'(width - 1));
            arready_i = 1'b1;
            tick();
            arready_i = 1'b0;
        end
        check_flag("arvalid_o", arvalid_o, 1'b0);
        ia = 0;
        ib = 0;
        while (ia < width || ib < width) begin
            random_wait();
            if (ia == width) begin
                pick_b = 1'b1;
            end else if (ib == width) begin
                pick_b = 1'b0;
            end else begin
                pick_b = $urandom_range(1);
            end
            rvalid_i = 1'b1;
            rid_i    = axi_id_t'(pick_b);
            rdata_i  = pick_b ? b_words[ib] : a_words[ia];
            rlast_i  = pick_b ? (ib == width - 1) : (ia == width - 1);
            while (!rready_o) tick();
            tick();
            rvalid_i = 1'b0;
            if (pick_b) begin
                ib++;
            end else begin
                ia++;
            end
        end
    endtask

    task automatic serve_writes(input axi_addr_t c_addr);
        while (!awvalid_o) tick();
        random_wait();
        check_addr("awaddr_o", awaddr_o, c_addr);
        check_len("awlen_o", awlen_o, 8'd15);
        awready_i = 1'b1;
        tick();
        awready_i = 1'b0;
        for (int b = 0; b < 16; b++) begin
            while (!wvalid_o) tick();
            random_wait();
            check_data("wdata_o", wdata_o, c_exp[b]);
            check_flag("wlast_o", wlast_o, b == 15);
            wready_i = 1'b1;
            tick();
            wready_i = 1'b0;
        end
        check_flag("wvalid_o", wvalid_o, 1'b0);
        random_wait();
        bvalid_i = 1'b1;
        while (!bready_o) tick();
        tick();
        bvalid_i = 1'b0;
    endtask

    // done pulse monitor sampled on the falling edge
    always @(negedge clk) begin
        if (done_o) begin
            if (!b_hs_last) fail_run("done_o pulsed without a write response the cycle before");
            done_count++;
        end
        b_hs_last = bvalid_i && bready_o;
    end

    initial begin
        wait (n_cases > 0);
        #(CLK_PERIOD * (RESET_CYCLES + 10 + CASE_CYCLES * n_cases));
        fail_run("the run timed out waiting for done_o");
    end

    initial begin
        int ptr;
        int found;
        void'($urandom(SEED));
        clk = 1'b0;
        rst_n = 1'b0;
        start_i = 1'b0;
        mat_a_addr_i = '0;
        mat_b_addr_i = '0;
        mat_c_addr_i = '0;
        mat_width_i = '0;
        arready_i = 1'b0;
        rvalid_i = 1'b0;
        rdata_i = '0;
        rid_i = '0;
        rlast_i = 1'b0;
        awready_i = 1'b0;
        wready_i = 1'b0;
        bvalid_i = 1'b0;
        done_count = 0;
        b_hs_last = 1'b0;

        $readmemh(VEC_FILE, vec_mem);
        ptr = 0;
        found = 0;
        while (ptr < VEC_DEPTH && !$isunknown(vec_mem[ptr]) && vec_mem[ptr] != 0) begin
            if (vec_mem[ptr] > 16) fail_run("the vector file holds a width above 16");
            found++;
            ptr += 20 + 2 * vec_mem[ptr];
        end
        if (found == 0) fail_run("no test case could be read from the vector file");
        n_cases = found;

        repeat (RESET_CYCLES) tick();
        rst_n = 1'b1;
        repeat (5) begin
            tick();
            check_quiet();
        end

        ptr = 0;
        for (int c = 0; c < n_cases; c++) begin
            width = vec_mem[ptr];
            mat_width_i = 5'(width);
            mat_a_addr_i = vec_mem[ptr + 1];
            mat_b_addr_i = vec_mem[ptr + 2];
            mat_c_addr_i = vec_mem[ptr + 3];
            for (int k = 0; k < width; k++) begin
                a_words[k] = vec_mem[ptr + 4 + k];
                b_words[k] = vec_mem[ptr + 4 + width + k];
            end
            for (int n = 0; n < 16; n++) begin
                c_exp[n] = vec_mem[ptr + 4 + 2 * width + n];
            end
            ptr += 20 + 2 * width;
            tick();
            start_i = 1'b1;
            tick();
            start_i = 1'b0;
            fork
                serve_reads(mat_a_addr_i, mat_b_addr_i);
                serve_writes(mat_c_addr_i);
                // a start while busy must be ignored
                begin
                    repeat (3) tick();
                    start_i = 1'b1;
                    tick();
                    start_i = 1'b0;
                end
            join
            while (done_count < c + 1) tick();
            repeat (4) begin
                tick();
                check_quiet();
            end
            if (done_count != c + 1) fail_run("done_o pulsed more than once in a case");
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
gemm_pkg.sv
axi_ch_if.sv
operand_buffer.sv
mm_engine.sv
dma_engine.sv
gemm_top.sv
tb_gemm.sv
